/* logic/frogger_pkg.sv */
// Sizes assume a 160x120 frame buffer; LANE_STEP_CYCLES is short for simulation only
`default_nettype none

package frogger_pkg;

    typedef logic [3:0]  grid_col_t;   // 16 columns
    typedef logic [2:0]  grid_row_t;   // 8 rows
    typedef logic [7:0]  pix_x_t;
    typedef logic [6:0]  pix_y_t;
    typedef logic [2:0]  colour_t;
    typedef logic [15:0] lane_word_t;  // One bit per column, column 0 in bit 15

    // Cell pitch and painted block size in pixels
    localparam int CELL_W     = 10;
    localparam int CELL_H     = 15;
    localparam int BLOCK_SIDE = 8;

    localparam grid_col_t FROG_HOME_COL = 4'd8;
    localparam grid_row_t FROG_HOME_ROW = 3'd6;

    localparam int        LANE_COUNT     = 4;
    localparam grid_row_t FIRST_LANE_ROW = 3'd1;
    localparam grid_row_t LAST_LANE_ROW  = grid_row_t'(FIRST_LANE_ROW + LANE_COUNT - 1);

    // Start patterns of the four rings
    localparam lane_word_t LANE_INIT [LANE_COUNT] = '{
        16'b1000_1101_1000_0000,
        16'b1100_0011_0001_0011,
        16'b0011_0111_0001_1001,
        16'b0110_0011_1001_1100
    };

    localparam colour_t COLOUR_FROG  = 3'd7;  // White
    localparam colour_t COLOUR_CAR   = 3'd6;  // Yellow
    localparam colour_t COLOUR_EMPTY = 3'd0;

    // 25_000_000 gives half a second on a 50 MHz board
    localparam int LANE_STEP_CYCLES = 1000;

endpackage

`default_nettype wire

/* logic/lane_step_timer.sv */
// One-cycle tick every LANE_STEP_CYCLES clocks; first tick LANE_STEP_CYCLES clocks after reset
`default_nettype none

module lane_step_timer (
    input  logic fastclock,
    input  logic resetn,
    output logic step_tick
);
    import frogger_pkg::*;

    localparam int               CNT_W  = $clog2(LANE_STEP_CYCLES);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(LANE_STEP_CYCLES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            count     <= RELOAD;
            step_tick <= 1'b0;
        end else if (count == '0) begin
            count     <= RELOAD;
            step_tick <= 1'b1;    // Single clock wide
        end else begin
            count     <= count - 1'b1;
            step_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/traffic_lanes.sv */
// Lookups are combinational and see the rings before a rotation in the same cycle
`default_nettype none

module traffic_lanes (
    input  logic                   fastclock,
    input  logic                   resetn,
    input  logic                   step_tick,
    input  frogger_pkg::grid_col_t scan_col,
    input  frogger_pkg::grid_row_t scan_row,
    input  frogger_pkg::grid_col_t frog_col,
    input  frogger_pkg::grid_row_t frog_row,
    output logic                   scan_busy,
    output logic                   frog_hit
);
    import frogger_pkg::*;

    localparam int LANE_W = $clog2(LANE_COUNT);

    lane_word_t lanes [LANE_COUNT];

    // Each ring rotates left by one on a step
    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                lanes[l] <= LANE_INIT[l];
            end
        end else if (step_tick) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                lanes[l] <= {lanes[l][14:0], lanes[l][15]};
            end
        end
    end

    // Occupancy of one cell, zero off the lane rows
    function automatic logic cell_busy(grid_col_t col, grid_row_t row);
        logic [LANE_W-1:0] lane;
        lane = LANE_W'(row - FIRST_LANE_ROW);
        if (row < FIRST_LANE_ROW || row > LAST_LANE_ROW) begin
            return 1'b0;
        end
        return lanes[lane][4'd15 - col];   // Column 0 is the top bit
    endfunction

    always_comb begin
        scan_busy = cell_busy(scan_col, scan_row);
        frog_hit  = cell_busy(frog_col, frog_row);
    end

endmodule

`default_nettype wire

/* logic/frog_position.sv */
// Key presses are caught on their rising edge and applied at the next move strobe
`default_nettype none

module frog_position (
    input  logic                   fastclock,
    input  logic                   resetn,
    input  logic                   key_up,
    input  logic                   key_down,
    input  logic                   key_left,
    input  logic                   key_right,
    input  logic                   move_strobe,
    input  logic                   frog_hit,
    output frogger_pkg::grid_col_t frog_col,
    output frogger_pkg::grid_row_t frog_row,
    output logic                   went_home
);
    import frogger_pkg::*;

    // Bit positions in the key vectors
    localparam int K_UP    = 3;
    localparam int K_DOWN  = 2;
    localparam int K_LEFT  = 1;
    localparam int K_RIGHT = 0;

    logic [3:0] keys;
    logic [3:0] keys_q;
    logic [3:0] key_rise;
    logic [3:0] pend;      // Presses not yet applied
    logic [3:0] step;

    assign keys     = {key_up, key_down, key_left, key_right};
    assign key_rise = keys & ~keys_q;
    assign step     = pend | key_rise;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            keys_q    <= '0;
            pend      <= '0;
            frog_col  <= FROG_HOME_COL;
            frog_row  <= FROG_HOME_ROW;
            went_home <= 1'b0;
        end else begin
            keys_q    <= keys;
            went_home <= frog_hit;   // Hit clears once home, so one cycle
            if (move_strobe) begin
                pend <= '0;
            end else begin
                pend <= step;
            end
            // Homing beats a move; grid widths give the wrap
            if (frog_hit) begin
                frog_col <= FROG_HOME_COL;
                frog_row <= FROG_HOME_ROW;
            end else if (move_strobe) begin
                frog_row <= frog_row + grid_row_t'(step[K_DOWN]) - grid_row_t'(step[K_UP]);
                frog_col <= frog_col + grid_col_t'(step[K_RIGHT]) - grid_col_t'(step[K_LEFT]);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/block_painter.sv */
// Wishbone classic write master; start is ignored while a block is in flight
`default_nettype none

module block_painter (
    input  logic                   fastclock,
    input  logic                   resetn,
    input  logic                   start,
    input  frogger_pkg::grid_col_t cell_col,
    input  frogger_pkg::grid_row_t cell_row,
    input  frogger_pkg::colour_t   block_colour,
    output logic                   done,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [14:0]            wb_adr,
    output frogger_pkg::colour_t   wb_dat,
    input  logic                   wb_ack
);
    import frogger_pkg::*;

    localparam int               OFS_W    = $clog2(BLOCK_SIDE);
    localparam int               PIX_W    = 2 * OFS_W;
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(BLOCK_SIDE * BLOCK_SIDE - 1);

    logic             busy;
    logic [PIX_W-1:0] pix_cnt;   // Low bits x offset, high bits y offset
    pix_x_t           org_x;
    pix_y_t           org_y;
    colour_t          colour_q;

    // Block origin and colour, held until the last ack
    always_ff @(posedge fastclock) begin
        if (start && !busy) begin
            org_x    <= pix_x_t'(cell_col * CELL_W);
            org_y    <= pix_y_t'(cell_row * CELL_H);
            colour_q <= block_colour;
        end
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            busy    <= 1'b0;
            pix_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    pix_cnt <= '0;
                end
            end else if (wb_ack) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == PIX_LAST) begin
                    busy <= 1'b0;   // Cycle ends right after the 64th ack
                    done <= 1'b1;
                end
            end
        end
    end

    // One write per pixel, cyc held across the whole block
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = busy;
    assign wb_adr = {org_y + pix_y_t'(pix_cnt[PIX_W-1:OFS_W]),
                     org_x + pix_x_t'(pix_cnt[OFS_W-1:0])};
    assign wb_dat = colour_q;

endmodule

`default_nettype wire

/* logic/scene_sequencer.sv */
// Frog redraws win over the scan only between blocks; a block is never cut short
`default_nettype none

module scene_sequencer (
    input  logic                   fastclock,
    input  logic                   resetn,
    input  logic                   key_up,
    input  logic                   key_down,
    input  logic                   key_left,
    input  logic                   key_right,
    input  logic                   went_home,
    input  logic                   scan_busy,
    input  frogger_pkg::grid_col_t frog_col,
    input  frogger_pkg::grid_row_t frog_row,
    input  logic                   painter_done,
    output logic                   move_strobe,
    output logic                   painter_start,
    output frogger_pkg::grid_col_t cell_col,
    output frogger_pkg::grid_row_t cell_row,
    output frogger_pkg::colour_t   block_colour,
    output frogger_pkg::grid_col_t scan_col,
    output frogger_pkg::grid_row_t scan_row
);
    import frogger_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ERASE,
        S_MOVE,
        S_DRAW,
        S_RELEASE,
        S_SCAN
    } state_t;

    state_t     state;
    logic [3:0] keys;
    logic [3:0] keys_q;
    logic       any_key;
    logic       key_rise;
    logic       key_pend;    // Press seen, redraw not yet started
    logic       home_pend;   // Frog sent home, home cell not yet drawn

    assign keys     = {key_up, key_down, key_left, key_right};
    assign any_key  = |keys;
    assign key_rise = |(keys & ~keys_q);

    // Scan walks the lane rows column by column
    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            scan_col <= '0;
            scan_row <= FIRST_LANE_ROW;
        end else if (state == S_SCAN && painter_done) begin
            scan_col <= scan_col + 1'b1;
            if (scan_col == '1) begin
                scan_row <= (scan_row == LAST_LANE_ROW) ? FIRST_LANE_ROW : scan_row + 1'b1;
            end
        end
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state         <= S_IDLE;
            painter_start <= 1'b0;
            keys_q        <= '0;
            key_pend      <= 1'b0;
            home_pend     <= 1'b0;
        end else begin
            keys_q        <= keys;
            painter_start <= 1'b0;
            if (key_rise) begin
                key_pend <= 1'b1;
            end
            if (went_home) begin
                home_pend <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    painter_start <= 1'b1;   // Every exit paints a block
                    if (key_pend) begin
                        state    <= S_ERASE;
                        key_pend <= 1'b0;
                    end else if (home_pend) begin
                        state     <= S_DRAW;
                        home_pend <= 1'b0;
                    end else begin
                        state <= S_SCAN;
                    end
                end
                S_ERASE: if (painter_done) state <= S_MOVE;
                S_MOVE: begin
                    state         <= S_DRAW;  // Frog cell is the new one from here
                    painter_start <= 1'b1;
                end
                S_DRAW: if (painter_done) state <= S_RELEASE;
                S_RELEASE: if (!any_key) state <= S_IDLE;
                S_SCAN: if (painter_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign move_strobe = (state == S_MOVE);

    // Painter samples these in the start cycle only
    always_comb begin
        if (state == S_SCAN) begin
            cell_col = scan_col;
            cell_row = scan_row;
        end else begin
            cell_col = frog_col;
            cell_row = frog_row;
        end
        case (state)
            S_DRAW: block_colour = COLOUR_FROG;
            S_SCAN: begin
                if (scan_col == frog_col && scan_row == frog_row) begin
                    block_colour = COLOUR_FROG;   // Keep the frog on top
                end else if (scan_busy) begin
                    block_colour = COLOUR_CAR;
                end else begin
                    block_colour = COLOUR_EMPTY;
                end
            end
            default: block_colour = COLOUR_EMPTY;   // Erase
        endcase
    end

endmodule

`default_nettype wire

/* logic/frogger_top.sv */
// Keys must arrive synchronised to fastclock; frame buffer sits behind the Wishbone port
`default_nettype none

module frogger_top (
    input  logic                 fastclock,
    input  logic                 resetn,
    input  logic                 key_up,
    input  logic                 key_down,
    input  logic                 key_left,
    input  logic                 key_right,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [14:0]          wb_adr,
    output frogger_pkg::colour_t wb_dat,
    input  logic                 wb_ack
);
    import frogger_pkg::*;

    logic      step_tick;
    logic      scan_busy;
    logic      frog_hit;
    logic      went_home;
    logic      move_strobe;
    logic      painter_start;
    logic      painter_done;
    grid_col_t scan_col;
    grid_row_t scan_row;
    grid_col_t frog_col;
    grid_row_t frog_row;
    grid_col_t cell_col;
    grid_row_t cell_row;
    colour_t   block_colour;

    lane_step_timer u_timer (
        .fastclock (fastclock),
        .resetn    (resetn),
        .step_tick (step_tick)
    );

    traffic_lanes u_lanes (
        .fastclock (fastclock),
        .resetn    (resetn),
        .step_tick (step_tick),
        .scan_col  (scan_col),
        .scan_row  (scan_row),
        .frog_col  (frog_col),
        .frog_row  (frog_row),
        .scan_busy (scan_busy),
        .frog_hit  (frog_hit)
    );

    frog_position u_frog (
        .fastclock   (fastclock),
        .resetn      (resetn),
        .key_up      (key_up),
        .key_down    (key_down),
        .key_left    (key_left),
        .key_right   (key_right),
        .move_strobe (move_strobe),
        .frog_hit    (frog_hit),
        .frog_col    (frog_col),
        .frog_row    (frog_row),
        .went_home   (went_home)
    );

    scene_sequencer u_seq (
        .fastclock     (fastclock),
        .resetn        (resetn),
        .key_up        (key_up),
        .key_down      (key_down),
        .key_left      (key_left),
        .key_right     (key_right),
        .went_home     (went_home),
        .scan_busy     (scan_busy),
        .frog_col      (frog_col),
        .frog_row      (frog_row),
        .painter_done  (painter_done),
        .move_strobe   (move_strobe),
        .painter_start (painter_start),
        .cell_col      (cell_col),
        .cell_row      (cell_row),
        .block_colour  (block_colour),
        .scan_col      (scan_col),
        .scan_row      (scan_row)
    );

    block_painter u_painter (
        .fastclock    (fastclock),
        .resetn       (resetn),
        .start        (painter_start),
        .cell_col     (cell_col),
        .cell_row     (cell_row),
        .block_colour (block_colour),
        .done         (painter_done),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack)
    );

endmodule

`default_nettype wire

/* bench/frame_buffer_model.sv */
// Wishbone classic slave with 0 to 3 wait states; expects one block per cyc and logs it at cyc fall
`default_nettype none

module frame_buffer_model (
    input  logic                 fastclock,
    input  logic                 resetn,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [14:0]          wb_adr,
    input  frogger_pkg::colour_t wb_dat,
    output logic                 wb_ack,
    output logic                 blk_done,
    output logic [14:0]          blk_first,
    output frogger_pkg::colour_t blk_colour,
    output int                   blk_writes,
    output logic                 blk_order_ok,
    output logic                 blk_uniform,
    output logic                 blk_dup,
    output int                   total_blocks,
    output int                   logged_writes
);
    timeunit 1ns;
    timeprecision 100ps;
    import frogger_pkg::*;

    int          wait_left;
    int          writes;        // Acks in the current block
    int          total_writes;
    logic [14:0] first;
    logic [14:0] exp_adr;
    colour_t     colour0;
    logic        order_ok;
    logic        uniform;
    logic        dup;
    logic        cyc_q;
    logic [14:0] seen_q [$];
    colour_t     mem [0:32767];

    // Row-major position of the next pixel
    assign exp_adr = {first[14:8] + 7'(writes[5:3]), first[7:0] + 8'(writes[2:0])};
    assign wb_ack  = wb_cyc && wb_stb && wb_we && (wait_left == 0);

    function automatic logic addr_seen(logic [14:0] adr);
        foreach (seen_q[i]) begin
            if (seen_q[i] == adr) return 1'b1;
        end
        return 1'b0;
    endfunction

    always @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            wait_left     <= 0;
            writes        <= 0;
            total_writes  <= 0;
            total_blocks  <= 0;
            logged_writes <= 0;
            cyc_q         <= 1'b0;
            blk_done      <= 1'b0;
            order_ok      <= 1'b1;
            uniform       <= 1'b1;
            dup           <= 1'b0;
            seen_q.delete();
        end else begin
            cyc_q    <= wb_cyc;
            blk_done <= 1'b0;
            if (wb_ack) begin
                wait_left        <= int'($urandom_range(3, 0));
                mem[wb_adr]      <= wb_dat;
                total_writes     <= total_writes + 1;
                writes           <= writes + 1;
                if (writes == 0) begin
                    first   <= wb_adr;
                    colour0 <= wb_dat;
                end else begin
                    if (wb_adr != exp_adr) order_ok <= 1'b0;
                    if (wb_dat != colour0) uniform <= 1'b0;
                end
                if (addr_seen(wb_adr)) dup <= 1'b1;
                seen_q.push_back(wb_adr);
            end else if (wb_stb && wait_left != 0) begin
                wait_left <= wait_left - 1;
            end
            // Block is over once cyc drops
            if (cyc_q && !wb_cyc) begin
                blk_done      <= 1'b1;
                blk_first     <= first;
                blk_colour    <= colour0;
                blk_writes    <= writes;
                blk_order_ok  <= order_ok;
                blk_uniform   <= uniform;
                blk_dup       <= dup;
                total_blocks  <= total_blocks + 1;
                logged_writes <= total_writes;
                writes        <= 0;
                order_ok      <= 1'b1;
                uniform       <= 1'b1;
                dup           <= 1'b0;
                seen_q.delete();
            end
        end
    end

endmodule

`default_nettype wire

/* bench/frogger_tb.sv */
// Frog stays off lane rows except in the final collision step; run spans at least five lane steps
`default_nettype none

module frogger_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import frogger_pkg::*;

    localparam int WATCHDOG_CYCLES = 6 * LANE_STEP_CYCLES + 200 * 300;
    localparam int REDRAW_TIMEOUT  = 3000;
    localparam int K_UP    = 0;
    localparam int K_DOWN  = 1;
    localparam int K_LEFT  = 2;
    localparam int K_RIGHT = 3;

    logic        fastclock;
    logic        resetn;
    logic        key_up;
    logic        key_down;
    logic        key_left;
    logic        key_right;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [14:0] wb_adr;
    colour_t     wb_dat;
    logic        wb_ack;
    logic        blk_done;
    logic [14:0] blk_first;
    colour_t     blk_colour;
    int          blk_writes;
    logic        blk_order_ok;
    logic        blk_uniform;
    logic        blk_dup;
    int          total_blocks;
    int          logged_writes;

    int hs_errors;
    int block_errors;
    int traffic_errors;
    int frog_errors;

    // Reference lanes, counted from reset release
    int         cnt;
    logic       ref_tick;
    lane_word_t ref_lanes [LANE_COUNT];
    lane_word_t lanes_d [LANE_COUNT];
    lane_word_t start_lanes [LANE_COUNT];   // Lanes in the cycle before cyc rose
    logic       cyc_q;

    grid_col_t   frog_col_exp;
    grid_row_t   frog_row_exp;
    logic        lane_frog_ok;
    grid_col_t   lane_frog_col;
    grid_row_t   lane_frog_row;
    logic [9:0]  frog_q [$];                 // {colour, col, row} of off-lane blocks

    frogger_top DUT (
        .fastclock (fastclock),
        .resetn    (resetn),
        .key_up    (key_up),
        .key_down  (key_down),
        .key_left  (key_left),
        .key_right (key_right),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack)
    );

    frame_buffer_model fb (
        .fastclock     (fastclock),
        .resetn        (resetn),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat        (wb_dat),
        .wb_ack        (wb_ack),
        .blk_done      (blk_done),
        .blk_first     (blk_first),
        .blk_colour    (blk_colour),
        .blk_writes    (blk_writes),
        .blk_order_ok  (blk_order_ok),
        .blk_uniform   (blk_uniform),
        .blk_dup       (blk_dup),
        .total_blocks  (total_blocks),
        .logged_writes (logged_writes)
    );

    always #2 fastclock = ~fastclock;

    always @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            cnt      <= 0;
            ref_tick <= 1'b0;
            for (int l = 0; l < LANE_COUNT; l++) ref_lanes[l] <= LANE_INIT[l];
        end else begin
            cnt      <= cnt + 1;
            ref_tick <= ((cnt + 1) % LANE_STEP_CYCLES == 0);
            if (ref_tick) begin
                for (int l = 0; l < LANE_COUNT; l++) begin
                    ref_lanes[l] <= {ref_lanes[l][14:0], ref_lanes[l][15]};
                end
            end
        end
    end

    always @(posedge fastclock) begin
        lanes_d <= ref_lanes;
        cyc_q   <= wb_cyc;
        if (wb_cyc && !cyc_q) start_lanes <= lanes_d;
    end

    function automatic colour_t traffic_colour(grid_col_t col, grid_row_t row);
        int lane;
        lane = int'(row) - int'(FIRST_LANE_ROW);
        if (start_lanes[lane][15 - int'(col)]) return COLOUR_CAR;
        return COLOUR_EMPTY;
    endfunction

    // Frog coloured pixels left in the stored home block
    function automatic int home_frog_pixels();
        int x0;
        int y0;
        int hits;
        x0   = int'(FROG_HOME_COL) * CELL_W;
        y0   = int'(FROG_HOME_ROW) * CELL_H;
        hits = 0;
        for (int dy = 0; dy < BLOCK_SIDE; dy++) begin
            for (int dx = 0; dx < BLOCK_SIDE; dx++) begin
                if (fb.mem[{7'(y0 + dy), 8'(x0 + dx)}] == COLOUR_FROG) hits++;
            end
        end
        return hits;
    endfunction

    // Bus handshake
    assert property (@(posedge fastclock) !resetn |-> !wb_cyc && !wb_stb)
        else begin hs_errors++; $display("Bus active during reset"); end
    assert property (@(posedge fastclock) $rose(resetn) |-> !wb_cyc && !wb_stb)
        else begin hs_errors++; $display("Bus active right after reset"); end
    assert property (@(posedge fastclock) disable iff (!resetn) wb_stb |-> wb_cyc && wb_we)
        else begin hs_errors++; $display("Strobe seen without cyc or we"); end
    assert property (@(posedge fastclock) disable iff (!resetn)
                     wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat))
        else begin hs_errors++; $display("Address or data changed while waiting for ack"); end

    // Per-block checks
    always @(posedge fastclock) begin : check_block
        int        x0;
        int        y0;
        grid_col_t col;
        grid_row_t row;
        colour_t   exp_c;
        if (blk_done) begin
            x0  = int'(blk_first[7:0]);
            y0  = int'(blk_first[14:8]);
            col = grid_col_t'(x0 / CELL_W);
            row = grid_row_t'(y0 / CELL_H);
            assert (blk_writes == 64) else begin
                block_errors++;
                $display("Mismatch block_size: expected %0d, actual %0d", 64, blk_writes);
            end
            assert (blk_uniform) else begin
                block_errors++;
                $display("Block at %h changed colour part way", blk_first);
            end
            assert (blk_order_ok && !blk_dup) else begin
                block_errors++;
                $display("Block at %h is not in row-major order or repeats a pixel", blk_first);
            end
            assert (x0 % CELL_W == 0 && y0 % CELL_H == 0 && x0 < 16 * CELL_W && y0 < 8 * CELL_H)
            else begin
                block_errors++;
                $display("Block origin %h is not a cell origin", blk_first);
            end
            if (row >= FIRST_LANE_ROW && row <= LAST_LANE_ROW) begin
                if (blk_colour == COLOUR_FROG) begin
                    assert (lane_frog_ok && col == lane_frog_col && row == lane_frog_row)
                    else begin
                        traffic_errors++;
                        $display("Frog drawn in lane cell (%0d,%0d) with no frog there", col, row);
                    end
                end else begin
                    exp_c = traffic_colour(col, row);
                    assert (blk_colour == exp_c) else begin
                        traffic_errors++;
                        $display("Mismatch traffic_colour (%0d,%0d): expected %0d, actual %0d",
                                 col, row, exp_c, blk_colour);
                    end
                end
            end else begin
                frog_q.push_back({blk_colour, col, row});
            end
        end
    end

    task automatic drive_key(int code, logic level);
        case (code)
            K_UP:    key_up    <= level;
            K_DOWN:  key_down  <= level;
            K_LEFT:  key_left  <= level;
            default: key_right <= level;
        endcase
    endtask

    task automatic press_key(int code, int hold);
        @(posedge fastclock);
        drive_key(code, 1'b1);
        repeat (hold) @(posedge fastclock);
        drive_key(code, 1'b0);
    endtask

    // Press, then expect erase of the old cell and one draw of the new one
    task automatic step_frog(int code, int hold);
        grid_col_t  new_col;
        grid_row_t  new_row;
        int         waited;
        logic [9:0] exp_erase;
        logic [9:0] exp_draw;
        new_col = frog_col_exp;
        new_row = frog_row_exp;
        case (code)
            K_UP:    new_row = frog_row_exp - 3'd1;
            K_DOWN:  new_row = frog_row_exp + 3'd1;
            K_LEFT:  new_col = frog_col_exp - 4'd1;
            default: new_col = frog_col_exp + 4'd1;
        endcase
        exp_erase = {COLOUR_EMPTY, frog_col_exp, frog_row_exp};
        exp_draw  = {COLOUR_FROG, new_col, new_row};
        frog_q.delete();
        press_key(code, hold);
        waited = 0;
        while (frog_q.size() < 2 && waited < REDRAW_TIMEOUT) begin
            @(posedge fastclock);
            waited++;
        end
        assert (frog_q.size() >= 2) else begin
            frog_errors++;
            $display("No frog redraw within %0d cycles of a key press", REDRAW_TIMEOUT);
        end
        if (frog_q.size() >= 2) begin
            assert (frog_q[0] == exp_erase) else begin
                frog_errors++;
                $display("Mismatch frog_erase: expected %h, actual %h", exp_erase, frog_q[0]);
            end
            assert (frog_q[1] == exp_draw) else begin
                frog_errors++;
                $display("Mismatch frog_draw: expected %h, actual %h", exp_draw, frog_q[1]);
            end
        end
        frog_col_exp = new_col;
        frog_row_exp = new_row;
        repeat (600) @(posedge fastclock);
        assert (frog_q.size() == 2) else begin
            frog_errors++;
            $display("Mismatch frog_single_move: expected %0d, actual %0d", 2, frog_q.size());
        end
    endtask

    // Step up into a car early in a lane period, then expect the home draw
    task automatic collide_and_home();
        int         waited;
        int         lane;
        int         bit_idx;
        logic       found;
        logic [9:0] exp_home;
        lane     = int'(frog_row_exp) - 1 - int'(FIRST_LANE_ROW);
        bit_idx  = 15 - int'(frog_col_exp);
        exp_home = {COLOUR_FROG, FROG_HOME_COL, FROG_HOME_ROW};
        waited   = 0;
        while (!(ref_lanes[lane][bit_idx] && cnt % LANE_STEP_CYCLES > 2 &&
                 cnt % LANE_STEP_CYCLES < 60) && waited < 20 * LANE_STEP_CYCLES) begin
            @(posedge fastclock);
            waited++;
        end
        assert (waited < 20 * LANE_STEP_CYCLES) else begin
            frog_errors++;
            $display("No occupied lane cell found ahead of the frog");
        end
        lane_frog_col = frog_col_exp;
        lane_frog_row = frog_row_exp - 3'd1;
        lane_frog_ok  = 1'b1;
        frog_q.delete();
        press_key(K_UP, 5);
        found  = 1'b0;
        waited = 0;
        while (!found && waited < REDRAW_TIMEOUT) begin
            @(posedge fastclock);
            waited++;
            foreach (frog_q[i]) begin
                if (frog_q[i] == exp_home) found = 1'b1;
            end
        end
        assert (found) else begin
            frog_errors++;
            $display("Frog was not drawn at home after a collision");
        end
        lane_frog_ok = 1'b0;   // Frog is home, no lane cell may show it now
        frog_col_exp = FROG_HOME_COL;
        frog_row_exp = FROG_HOME_ROW;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge fastclock);
        $display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(83));
        fastclock      = 1'b0;
        resetn         = 1'b0;
        key_up         = 1'b0;
        key_down       = 1'b0;
        key_left       = 1'b0;
        key_right      = 1'b0;
        hs_errors      = 0;
        block_errors   = 0;
        traffic_errors = 0;
        frog_errors    = 0;
        frog_col_exp   = FROG_HOME_COL;
        frog_row_exp   = FROG_HOME_ROW;
        lane_frog_ok   = 1'b0;
        repeat (3) @(posedge fastclock);
        resetn <= 1'b1;
        repeat (200) @(posedge fastclock);

        step_frog(K_RIGHT, 5);
        step_frog(K_DOWN, 5);
        step_frog(K_DOWN, 5);    // Wraps to row 0
        step_frog(K_UP, 5);
        step_frog(K_UP, 400);    // Long hold, one step
        step_frog(K_LEFT, 5);
        step_frog(K_UP, 5);
        collide_and_home();

        while (cnt < 5 * LANE_STEP_CYCLES) @(posedge fastclock);
        do @(posedge fastclock); while (wb_cyc);
        repeat (2) @(posedge fastclock);
        assert (total_blocks > 0 && logged_writes == 64 * total_blocks) else begin
            block_errors++;
            $display("Mismatch back_pressure_writes: expected %0d, actual %0d",
                     64 * total_blocks, logged_writes);
        end
        assert (home_frog_pixels() == BLOCK_SIDE * BLOCK_SIDE) else begin
            frog_errors++;
            $display("Mismatch home_block_pixels: expected %0d, actual %0d",
                     BLOCK_SIDE * BLOCK_SIDE, home_frog_pixels());
        end

        $display("Errors: handshake %0d, block %0d, traffic %0d, frog %0d",
                 hs_errors, block_errors, traffic_errors, frog_errors);
        if (hs_errors + block_errors + traffic_errors + frog_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
logic/frogger_pkg.sv
logic/lane_step_timer.sv
logic/traffic_lanes.sv
logic/frog_position.sv
logic/block_painter.sv
logic/scene_sequencer.sv
logic/frogger_top.sv
bench/frame_buffer_model.sv
bench/frogger_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module frogger_tb -f sources.f \
    --Mdir obj_dir -o frogger_sim

./obj_dir/frogger_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
grep -q "Everything OK" sim.log
